//--- hdl/cpu_pkg.sv
package cpu_pkg;

typedef logic [31:0] word_t;
typedef logic [29:0] waddr_t;
typedef logic [3:0] reg_sel_t;

// unknown codes decode as halt.
typedef enum logic [3:0] {
	op_add,
	op_sub,
	op_and,
	op_or,
	op_xor,
	op_addi,
	op_ldw,
	op_stw,
	op_beqz,
	op_halt
} opcode_e;

typedef enum logic [2:0] {
	alu_add,
	alu_sub,
	alu_and,
	alu_or,
	alu_xor
} alu_op_e;

localparam int op_msb = 31;
localparam int op_lsb = 28;
localparam int rd_msb = 27;
localparam int rd_lsb = 24;
localparam int ra_msb = 23;
localparam int ra_lsb = 20;
localparam int rb_msb = 19;
localparam int rb_lsb = 16;
localparam int imm_msb = 15;
localparam int imm_lsb = 0;

localparam int num_regs = 16;
localparam word_t reset_pc = 32'h0000_0000;

endpackage

//--- hdl/cpu_fetch.sv
module cpu_fetch(
	input logic clk,
	input logic i_arst_n,
	input logic i_i_ack,
	input cpu_pkg::word_t i_i_data,
	input logic i_branch_taken,
	input cpu_pkg::word_t i_branch_pc,
	input logic i_stall_clear,
	input logic i_mem_complete,
	input logic i_pipeline_busy,
	output logic o_i_access,
	output cpu_pkg::waddr_t o_i_addr,
	output cpu_pkg::word_t o_instr,
	output cpu_pkg::word_t o_pc_plus_4,
	output logic o_valid,
	output logic o_halted
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		fetching,
		waiting,
		stalled,
		halting,
		halted
	} fetch_state_e;

	fetch_state_e state;
	word_t pc;
	word_t pc_next;
	opcode_e opcode;

	assign pc_next = pc + 32'd4;
	assign opcode = opcode_e'(i_i_data[op_msb:op_lsb]);

	assign o_i_access = (state == fetching);
	assign o_i_addr = pc[31:2];
	assign o_halted = (state == halted);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= waiting;
			pc <= reset_pc;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			case (state)
			waiting: state <= fetching;
			fetching: begin
				if (i_i_ack) begin
					o_valid <= 1'b1;
					pc <= pc_next;
					case (opcode)
					op_add, op_sub, op_and, op_or, op_xor, op_addi: state <= fetching;
					// wait for execute or memory to release.
					op_ldw, op_stw, op_beqz: state <= stalled;
					default: state <= halting;
					endcase
				end
			end
			stalled: begin
				if (i_branch_taken) begin
					pc <= i_branch_pc;
					state <= fetching;
				end else if (i_stall_clear || i_mem_complete) begin
					state <= fetching;
				end
			end
			// drain everything still in flight.
			halting: if (!i_pipeline_busy) state <= halted;
			default: state <= halted;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fetching && i_i_ack) begin
			o_instr <= i_i_data;
			o_pc_plus_4 <= pc_next;
		end
	end

endmodule

//--- hdl/cpu_decode.sv
module cpu_decode(
	input logic clk,
	input logic i_arst_n,
	input cpu_pkg::word_t i_instr,
	input cpu_pkg::word_t i_pc_plus_4,
	input logic i_valid,
	output cpu_pkg::reg_sel_t o_ra_sel,
	output cpu_pkg::reg_sel_t o_rb_sel,
	output cpu_pkg::reg_sel_t o_rd_sel,
	output logic o_update_rd,
	output cpu_pkg::word_t o_imm32,
	output cpu_pkg::alu_op_e o_alu_op,
	output logic o_use_imm,
	output logic o_mem_load,
	output logic o_mem_store,
	output logic o_is_branch,
	output logic o_is_halt,
	output cpu_pkg::word_t o_pc_plus_4,
	output logic o_valid
);
	import cpu_pkg::*;

	opcode_e opcode;
	alu_op_e alu_op;
	word_t imm32;
	logic use_imm;
	logic update_rd;
	logic mem_load;
	logic mem_store;
	logic is_branch;
	logic is_halt;

	assign opcode = opcode_e'(i_instr[op_msb:op_lsb]);
	assign o_ra_sel = i_instr[ra_msb:ra_lsb];
	assign o_rb_sel = i_instr[rb_msb:rb_lsb];
	assign imm32 = {{16{i_instr[imm_msb]}}, i_instr[imm_msb:imm_lsb]};

	always_comb begin
		alu_op = alu_add;
		use_imm = 1'b0;
		update_rd = 1'b0;
		mem_load = 1'b0;
		mem_store = 1'b0;
		is_branch = 1'b0;
		is_halt = 1'b0;
		case (opcode)
		op_add: update_rd = 1'b1;
		op_sub: begin
			alu_op = alu_sub;
			update_rd = 1'b1;
		end
		op_and: begin
			alu_op = alu_and;
			update_rd = 1'b1;
		end
		op_or: begin
			alu_op = alu_or;
			update_rd = 1'b1;
		end
		op_xor: begin
			alu_op = alu_xor;
			update_rd = 1'b1;
		end
		op_addi: begin
			use_imm = 1'b1;
			update_rd = 1'b1;
		end
		// address is ra plus immediate.
		op_ldw: begin
			use_imm = 1'b1;
			update_rd = 1'b1;
			mem_load = 1'b1;
		end
		op_stw: begin
			use_imm = 1'b1;
			mem_store = 1'b1;
		end
		op_beqz: is_branch = 1'b1;
		op_halt: is_halt = 1'b1;
		default: is_halt = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
			o_update_rd <= 1'b0;
			o_mem_load <= 1'b0;
			o_mem_store <= 1'b0;
			o_is_branch <= 1'b0;
			o_is_halt <= 1'b0;
		end else begin
			o_valid <= i_valid;
			o_update_rd <= i_valid && update_rd;
			o_mem_load <= i_valid && mem_load;
			o_mem_store <= i_valid && mem_store;
			o_is_branch <= i_valid && is_branch;
			o_is_halt <= i_valid && is_halt;
		end
	end

	always_ff @(posedge clk) begin
		o_rd_sel <= i_instr[rd_msb:rd_lsb];
		o_imm32 <= imm32;
		o_alu_op <= alu_op;
		o_use_imm <= use_imm;
		o_pc_plus_4 <= i_pc_plus_4;
	end

endmodule

//--- hdl/cpu_exec.sv
module cpu_exec(
	input logic clk,
	input logic i_arst_n,
	input cpu_pkg::word_t i_ra,
	input cpu_pkg::word_t i_rb,
	input cpu_pkg::reg_sel_t i_rd_sel,
	input logic i_update_rd,
	input cpu_pkg::word_t i_imm32,
	input cpu_pkg::alu_op_e i_alu_op,
	input logic i_use_imm,
	input logic i_mem_load,
	input logic i_mem_store,
	input logic i_is_branch,
	input logic i_is_halt,
	input cpu_pkg::word_t i_pc_plus_4,
	input logic i_valid,
	input logic i_hold,
	output logic o_branch_taken,
	output logic o_stall_clear,
	output cpu_pkg::word_t o_alu_out,
	output cpu_pkg::word_t o_store_val,
	output cpu_pkg::reg_sel_t o_rd_sel,
	output logic o_update_rd,
	output logic o_load,
	output logic o_store,
	output logic o_valid
);
	import cpu_pkg::*;

	word_t op2;
	word_t alu_result;
	word_t branch_target;
	logic ra_zero;

	assign op2 = i_use_imm ? i_imm32 : i_rb;
	assign ra_zero = (i_ra == '0);
	assign branch_target = i_pc_plus_4 + {i_imm32[29:0], 2'b00};

	always_comb begin
		case (i_alu_op)
		alu_sub: alu_result = i_ra - op2;
		alu_and: alu_result = i_ra & op2;
		alu_or: alu_result = i_ra | op2;
		alu_xor: alu_result = i_ra ^ op2;
		default: alu_result = i_ra + op2;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_branch_taken <= 1'b0;
			o_stall_clear <= 1'b0;
			o_update_rd <= 1'b0;
			o_load <= 1'b0;
			o_store <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			o_branch_taken <= 1'b0;
			o_stall_clear <= 1'b0;
			if (!i_hold) begin
				o_branch_taken <= i_valid && i_is_branch && ra_zero;
				o_stall_clear <= i_valid && i_is_branch && !ra_zero;
				o_update_rd <= i_valid && i_update_rd;
				o_load <= i_valid && i_mem_load;
				o_store <= i_valid && i_mem_store;
				// halt retires here.
				o_valid <= i_valid && !i_is_halt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_hold) begin
			o_alu_out <= i_is_branch ? branch_target : alu_result;
			o_store_val <= i_rb;
			o_rd_sel <= i_rd_sel;
		end
	end

endmodule

//--- hdl/cpu_memory.sv
module cpu_memory(
	input logic clk,
	input logic i_arst_n,
	input cpu_pkg::word_t i_alu_out,
	input cpu_pkg::word_t i_store_val,
	input cpu_pkg::reg_sel_t i_rd_sel,
	input logic i_update_rd,
	input logic i_load,
	input logic i_store,
	input logic i_valid,
	input cpu_pkg::word_t i_d_data,
	input logic i_d_ack,
	output logic o_d_access,
	output cpu_pkg::waddr_t o_d_addr,
	output logic o_d_wr_en,
	output cpu_pkg::word_t o_d_wr_val,
	output logic o_busy,
	output logic o_complete,
	output cpu_pkg::word_t o_wr_val,
	output cpu_pkg::reg_sel_t o_rd_sel,
	output logic o_update_rd
);
	import cpu_pkg::*;

	logic access;

	// request held by the stalled execute/memory register.
	assign access = i_valid && (i_load || i_store);

	assign o_d_access = access;
	assign o_d_addr = i_alu_out[31:2];
	assign o_d_wr_en = access && i_store;
	assign o_d_wr_val = i_store_val;

	assign o_busy = access && !i_d_ack;
	assign o_complete = access && i_d_ack;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_update_rd <= 1'b0;
		end else begin
			o_update_rd <= i_valid && i_update_rd && !o_busy;
		end
	end

	// load data is valid in the ack cycle.
	always_ff @(posedge clk) begin
		if (!o_busy) begin
			o_wr_val <= i_load ? i_d_data : i_alu_out;
			o_rd_sel <= i_rd_sel;
		end
	end

endmodule

//--- hdl/cpu_regfile.sv
module cpu_regfile(
	input logic clk,
	input logic i_arst_n,
	input cpu_pkg::reg_sel_t i_ra_sel,
	input cpu_pkg::reg_sel_t i_rb_sel,
	input cpu_pkg::reg_sel_t i_rd_sel,
	input logic i_wr_en,
	input cpu_pkg::word_t i_wr_val,
	output cpu_pkg::word_t o_ra,
	output cpu_pkg::word_t o_rb
);
	import cpu_pkg::*;

	word_t regs [num_regs];

	// write-first bypass.
	assign o_ra = (i_wr_en && i_rd_sel == i_ra_sel) ? i_wr_val : regs[i_ra_sel];
	assign o_rb = (i_wr_en && i_rd_sel == i_rb_sel) ? i_wr_val : regs[i_rb_sel];

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en) begin
			regs[i_rd_sel] <= i_wr_val;
		end
	end

endmodule

//--- hdl/cpu_pipeline.sv
module cpu_pipeline(
	input logic clk,
	input logic i_arst_n,
	output logic o_i_access,
	output cpu_pkg::waddr_t o_i_addr,
	input cpu_pkg::word_t i_i_data,
	input logic i_i_ack,
	output logic o_d_access,
	output cpu_pkg::waddr_t o_d_addr,
	output logic o_d_wr_en,
	output cpu_pkg::word_t o_d_wr_val,
	input cpu_pkg::word_t i_d_data,
	input logic i_d_ack,
	output logic o_halted
);
	import cpu_pkg::*;

	word_t fd_instr;
	word_t fd_pc_plus_4;
	logic fd_valid;

	reg_sel_t d_ra_sel;
	reg_sel_t d_rb_sel;
	word_t rf_ra;
	word_t rf_rb;

	reg_sel_t de_rd_sel;
	logic de_update_rd;
	word_t de_imm32;
	alu_op_e de_alu_op;
	logic de_use_imm;
	logic de_mem_load;
	logic de_mem_store;
	logic de_is_branch;
	logic de_is_halt;
	word_t de_pc_plus_4;
	logic de_valid;

	logic ef_branch_taken;
	logic ef_stall_clear;
	word_t em_alu_out;
	word_t em_store_val;
	reg_sel_t em_rd_sel;
	logic em_update_rd;
	logic em_load;
	logic em_store;
	logic em_valid;

	logic m_busy;
	logic mf_complete;
	word_t mw_wr_val;
	reg_sel_t mw_rd_sel;
	logic mw_update_rd;

	logic pipeline_busy;
	logic ra_fwd_exec;
	logic ra_fwd_mem;
	logic rb_fwd_exec;
	logic rb_fwd_mem;
	word_t rf_ra_q;
	word_t rf_rb_q;
	word_t de_ra;
	word_t de_rb;

	assign pipeline_busy = fd_valid || de_valid || em_valid || m_busy;

	// youngest result wins.
	assign de_ra = ra_fwd_exec ? em_alu_out : ra_fwd_mem ? mw_wr_val : rf_ra_q;
	assign de_rb = rb_fwd_exec ? em_alu_out : rb_fwd_mem ? mw_wr_val : rf_rb_q;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ra_fwd_exec <= 1'b0;
			ra_fwd_mem <= 1'b0;
			rb_fwd_exec <= 1'b0;
			rb_fwd_mem <= 1'b0;
		end else begin
			ra_fwd_exec <= de_update_rd && de_rd_sel == d_ra_sel;
			ra_fwd_mem <= em_update_rd && em_rd_sel == d_ra_sel;
			rb_fwd_exec <= de_update_rd && de_rd_sel == d_rb_sel;
			rb_fwd_mem <= em_update_rd && em_rd_sel == d_rb_sel;
		end
	end

	always_ff @(posedge clk) begin
		rf_ra_q <= rf_ra;
		rf_rb_q <= rf_rb;
	end

	cpu_fetch u_fetch (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_i_ack(i_i_ack),
		.i_i_data(i_i_data),
		.i_branch_taken(ef_branch_taken),
		.i_branch_pc(em_alu_out),
		.i_stall_clear(ef_stall_clear),
		.i_mem_complete(mf_complete),
		.i_pipeline_busy(pipeline_busy),
		.o_i_access(o_i_access),
		.o_i_addr(o_i_addr),
		.o_instr(fd_instr),
		.o_pc_plus_4(fd_pc_plus_4),
		.o_valid(fd_valid),
		.o_halted(o_halted)
	);

	cpu_decode u_decode (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_instr(fd_instr),
		.i_pc_plus_4(fd_pc_plus_4),
		.i_valid(fd_valid),
		.o_ra_sel(d_ra_sel),
		.o_rb_sel(d_rb_sel),
		.o_rd_sel(de_rd_sel),
		.o_update_rd(de_update_rd),
		.o_imm32(de_imm32),
		.o_alu_op(de_alu_op),
		.o_use_imm(de_use_imm),
		.o_mem_load(de_mem_load),
		.o_mem_store(de_mem_store),
		.o_is_branch(de_is_branch),
		.o_is_halt(de_is_halt),
		.o_pc_plus_4(de_pc_plus_4),
		.o_valid(de_valid)
	);

	cpu_exec u_exec (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_ra(de_ra),
		.i_rb(de_rb),
		.i_rd_sel(de_rd_sel),
		.i_update_rd(de_update_rd),
		.i_imm32(de_imm32),
		.i_alu_op(de_alu_op),
		.i_use_imm(de_use_imm),
		.i_mem_load(de_mem_load),
		.i_mem_store(de_mem_store),
		.i_is_branch(de_is_branch),
		.i_is_halt(de_is_halt),
		.i_pc_plus_4(de_pc_plus_4),
		.i_valid(de_valid),
		.i_hold(m_busy),
		.o_branch_taken(ef_branch_taken),
		.o_stall_clear(ef_stall_clear),
		.o_alu_out(em_alu_out),
		.o_store_val(em_store_val),
		.o_rd_sel(em_rd_sel),
		.o_update_rd(em_update_rd),
		.o_load(em_load),
		.o_store(em_store),
		.o_valid(em_valid)
	);

	cpu_memory u_memory (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_alu_out(em_alu_out),
		.i_store_val(em_store_val),
		.i_rd_sel(em_rd_sel),
		.i_update_rd(em_update_rd),
		.i_load(em_load),
		.i_store(em_store),
		.i_valid(em_valid),
		.i_d_data(i_d_data),
		.i_d_ack(i_d_ack),
		.o_d_access(o_d_access),
		.o_d_addr(o_d_addr),
		.o_d_wr_en(o_d_wr_en),
		.o_d_wr_val(o_d_wr_val),
		.o_busy(m_busy),
		.o_complete(mf_complete),
		.o_wr_val(mw_wr_val),
		.o_rd_sel(mw_rd_sel),
		.o_update_rd(mw_update_rd)
	);

	cpu_regfile u_regfile (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_ra_sel(d_ra_sel),
		.i_rb_sel(d_rb_sel),
		.i_rd_sel(mw_rd_sel),
		.i_wr_en(mw_update_rd),
		.i_wr_val(mw_wr_val),
		.o_ra(rf_ra),
		.o_rb(rf_rb)
	);

endmodule

//--- tb/tb_clock.sv
module tb_clock(
	output logic o_clk,
	output logic o_arst_n
);
	logic clk_q = 1'b0;
	logic arst_n_q = 1'b0;

	assign o_clk = clk_q;
	assign o_arst_n = arst_n_q;

	always #2 clk_q = ~clk_q;

	// two cycles of active-low reset.
	task automatic pulse_reset();
		@(posedge clk_q);
		#1;
		arst_n_q = 1'b0;
		repeat (2) @(posedge clk_q);
		#1;
		arst_n_q = 1'b1;
	endtask

endmodule

//--- tb/tb_mem_model.sv
module tb_mem_model(
	input logic clk,
	input logic i_arst_n,
	input logic i_rand_en,
	input logic i_i_access,
	input cpu_pkg::waddr_t i_i_addr,
	output cpu_pkg::word_t o_i_data,
	output logic o_i_ack,
	input logic i_d_access,
	input cpu_pkg::waddr_t i_d_addr,
	input logic i_d_wr_en,
	input cpu_pkg::word_t i_d_wr_val,
	output cpu_pkg::word_t o_d_data,
	output logic o_d_ack
);
	import cpu_pkg::*;

	word_t mem [256];
	waddr_t log_addr [$];
	word_t log_data [$];
	integer seed = 68255;
	int i_cnt = 0;
	int i_delay = 0;
	int d_cnt = 0;
	int d_delay = 0;
	logic i_fire;
	logic i_wait;
	logic d_fire;
	logic d_wait;
	logic d_write;
	waddr_t d_addr_s;
	word_t d_val_s;

	// ack after the drawn number of idle cycles.
	assign o_i_ack = i_i_access && (i_cnt == i_delay);
	assign o_i_data = mem[i_i_addr[7:0]];
	assign o_d_ack = i_d_access && (d_cnt == d_delay);
	assign o_d_data = mem[i_d_addr[7:0]];

	function automatic int pick_delay();
		int d;
		d = 0;
		if (i_rand_en) begin
			d = int'($unsigned($random(seed)) % 4);
		end
		return d;
	endfunction

	task automatic fill_memory();
		for (int i = 0; i < 256; i++) begin
			mem[i] = (32'h9e37_79b9 * (i + 1)) ^ {24'h5a_c3f0, i[7:0]};
		end
	endtask

	task automatic load_word(input int idx, input word_t w);
		mem[idx[7:0]] = w;
	endtask

	always @(posedge clk) begin
		// sample the bus at the edge, act just after it.
		i_fire = i_i_access && o_i_ack;
		i_wait = i_i_access && !o_i_ack;
		d_fire = i_d_access && o_d_ack;
		d_wait = i_d_access && !o_d_ack;
		d_write = d_fire && i_d_wr_en;
		d_addr_s = i_d_addr;
		d_val_s = i_d_wr_val;
		#1;
		if (!i_arst_n) begin
			i_cnt = 0;
			i_delay = 0;
			d_cnt = 0;
			d_delay = 0;
			log_addr.delete();
			log_data.delete();
		end else begin
			if (i_fire) begin
				i_cnt = 0;
				i_delay = pick_delay();
			end else if (i_wait) begin
				i_cnt++;
			end
			if (d_fire) begin
				d_cnt = 0;
				d_delay = pick_delay();
			end else if (d_wait) begin
				d_cnt++;
			end
			if (d_write) begin
				mem[d_addr_s[7:0]] = d_val_s;
				log_addr.push_back(d_addr_s);
				log_data.push_back(d_val_s);
			end
		end
	end

endmodule

//--- tb/pipeline_props.sv
module pipeline_props(
	input logic clk,
	input logic i_arst_n,
	input logic o_i_access,
	input cpu_pkg::waddr_t o_i_addr,
	input logic i_i_ack,
	input logic o_d_access,
	input cpu_pkg::waddr_t o_d_addr,
	input logic o_d_wr_en,
	input cpu_pkg::word_t o_d_wr_val,
	input logic i_d_ack,
	input logic o_halted
);

	a_i_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_i_access && !i_i_ack |=> o_i_access && $stable(o_i_addr))
		else $error("instruction request changed before ack");

	a_d_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_d_access && !i_d_ack |=> o_d_access && $stable(o_d_addr)
			&& $stable(o_d_wr_en) && $stable(o_d_wr_val))
		else $error("data request changed before ack");

	a_no_fetch_halted: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_halted |-> !o_i_access)
		else $error("instruction request while halted");

	a_halt_sticky: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_halted |=> o_halted)
		else $error("halted dropped without reset");

endmodule

bind cpu_pipeline pipeline_props u_props (.*);

//--- tb/tb_top.sv
module tb_top;
	import cpu_pkg::*;

	logic clk;
	logic arst_n;
	logic rand_en = 1'b0;
	logic i_access;
	waddr_t i_addr;
	word_t i_data;
	logic i_ack;
	logic d_access;
	waddr_t d_addr;
	logic d_wr_en;
	word_t d_wr_val;
	word_t d_data;
	logic d_ack;
	logic halted;

	word_t prog [$];
	waddr_t exp_addr [$];
	word_t exp_data [$];

	tb_clock u_clk (.o_clk(clk), .o_arst_n(arst_n));

	tb_mem_model u_mem (
		.clk(clk), .i_arst_n(arst_n), .i_rand_en(rand_en),
		.i_i_access(i_access), .i_i_addr(i_addr), .o_i_data(i_data), .o_i_ack(i_ack),
		.i_d_access(d_access), .i_d_addr(d_addr), .i_d_wr_en(d_wr_en),
		.i_d_wr_val(d_wr_val), .o_d_data(d_data), .o_d_ack(d_ack)
	);

	cpu_pipeline DUT (
		.clk(clk), .i_arst_n(arst_n),
		.o_i_access(i_access), .o_i_addr(i_addr), .i_i_data(i_data), .i_i_ack(i_ack),
		.o_d_access(d_access), .o_d_addr(d_addr), .o_d_wr_en(d_wr_en),
		.o_d_wr_val(d_wr_val), .i_d_data(d_data), .i_d_ack(d_ack), .o_halted(halted)
	);

	function automatic word_t enc(opcode_e op, int rd, int ra, int rb, int imm);
		word_t w;
		w = {op, rd[3:0], ra[3:0], rb[3:0], imm[15:0]};
		return w;
	endfunction

	task automatic check_eq(input word_t actual, input word_t expected, input string msg);
		if (actual !== expected) begin
			$display("Error at time %0t: %s: got %h, expected %h", $time, msg, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_program();
		u_mem.fill_memory();
		foreach (prog[i]) u_mem.load_word(i, prog[i]);
	endtask

	task automatic wait_halted();
		int n;
		n = 0;
		while (!halted && n < 3000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!halted) begin
			$display("Timeout while waiting for o_halted to rise");
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	endtask

	task automatic wait_fetch();
		int n;
		n = 0;
		while (!i_access && n < 50) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!i_access) begin
			$display("Timeout while waiting for the first instruction request");
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	endtask

	task automatic run_program();
		u_clk.pulse_reset();
		wait_halted();
	endtask

	task automatic check_stores();
		check_eq(u_mem.log_addr.size(), exp_addr.size(), "store count");
		foreach (exp_addr[i]) begin
			check_eq({2'b00, u_mem.log_addr[i]}, {2'b00, exp_addr[i]}, "store address");
			check_eq(u_mem.log_data[i], exp_data[i], "store value");
		end
	endtask

	task automatic expect_store(input word_t byte_addr, input word_t val);
		exp_addr.push_back(byte_addr[31:2]);
		exp_data.push_back(val);
	endtask

	// each result feeds the next instruction.
	task automatic build_chain();
		word_t r1, r2, r3, r4, r5, r6, r7, r9;
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		prog.push_back(enc(op_addi, 8, 0, 0, 'h100));
		prog.push_back(enc(op_addi, 1, 0, 0, 'h1234));
		prog.push_back(enc(op_addi, 2, 1, 0, -3));
		prog.push_back(enc(op_add, 3, 1, 2, 0));
		prog.push_back(enc(op_sub, 4, 3, 1, 0));
		prog.push_back(enc(op_and, 5, 4, 3, 0));
		prog.push_back(enc(op_or, 6, 5, 1, 0));
		prog.push_back(enc(op_xor, 7, 6, 2, 0));
		prog.push_back(enc(op_stw, 0, 8, 7, 0));
		prog.push_back(enc(op_stw, 0, 8, 6, 4));
		prog.push_back(enc(op_stw, 0, 8, 5, 8));
		prog.push_back(enc(op_stw, 0, 8, 4, 12));
		prog.push_back(enc(op_stw, 0, 8, 3, 16));
		prog.push_back(enc(op_addi, 9, 0, 0, -8));
		prog.push_back(enc(op_stw, 0, 8, 9, 20));
		prog.push_back(enc(op_halt, 0, 0, 0, 0));
		r1 = 32'h1234;
		r2 = r1 - 32'd3;
		r3 = r1 + r2;
		r4 = r3 - r1;
		r5 = r4 & r3;
		r6 = r5 | r1;
		r7 = r6 ^ r2;
		r9 = 32'hffff_fff8;
		expect_store(32'h100, r7);
		expect_store(32'h104, r6);
		expect_store(32'h108, r5);
		expect_store(32'h10c, r4);
		expect_store(32'h110, r3);
		expect_store(32'h114, r9);
	endtask

	task automatic alu_chain();
		build_chain();
		load_program();
		run_program();
		check_stores();
	endtask

	task automatic load_use();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		prog.push_back(enc(op_addi, 1, 0, 0, 'h140));
		prog.push_back(enc(op_ldw, 2, 1, 0, 8));
		prog.push_back(enc(op_add, 3, 2, 1, 0));
		prog.push_back(enc(op_stw, 0, 1, 3, 4));
		prog.push_back(enc(op_halt, 0, 0, 0, 0));
		load_program();
		u_mem.load_word('h148 >> 2, 32'h1111_0000);
		expect_store(32'h144, 32'h1111_0000 + 32'h140);
		run_program();
		check_stores();
	endtask

	// taken target 4+4+1*4 skips the store at 8.
	task automatic branch_paths();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		prog.push_back(enc(op_addi, 1, 0, 0, 'h180));
		prog.push_back(enc(op_beqz, 0, 0, 0, 1));
		prog.push_back(enc(op_stw, 0, 1, 1, 0));
		prog.push_back(enc(op_addi, 2, 0, 0, 7));
		prog.push_back(enc(op_beqz, 0, 2, 0, 5));
		prog.push_back(enc(op_stw, 0, 1, 2, 4));
		prog.push_back(enc(op_halt, 0, 0, 0, 0));
		expect_store(32'h184, 32'd7);
		load_program();
		run_program();
		check_stores();
	endtask

	task automatic random_delay();
		build_chain();
		load_program();
		@(posedge clk);
		#1;
		rand_en = 1'b0;
		run_program();
		check_stores();
		load_program();
		@(posedge clk);
		#1;
		rand_en = 1'b1;
		run_program();
		check_stores();
		@(posedge clk);
		#1;
		rand_en = 1'b0;
	endtask

	task automatic halt_quiet();
		prog.delete();
		prog.push_back(enc(op_addi, 1, 0, 0, 1));
		prog.push_back(enc(op_halt, 0, 0, 0, 0));
		load_program();
		run_program();
		repeat (20) begin
			@(posedge clk);
			#1;
			check_eq(i_access, 1'b0, "request after halt");
			check_eq(halted, 1'b1, "o_halted after halt");
		end
	endtask

	task automatic reset_restart();
		build_chain();
		load_program();
		@(posedge clk);
		#1;
		rand_en = 1'b1;
		u_clk.pulse_reset();
		repeat (15) @(posedge clk);
		#1;
		check_eq(halted, 1'b0, "halted too early");
		// restart in the middle of the chain.
		u_clk.pulse_reset();
		wait_fetch();
		check_eq({2'b00, i_addr}, {2'b00, reset_pc[31:2]}, "restart address");
		wait_halted();
		check_stores();
		@(posedge clk);
		#1;
		rand_en = 1'b0;
	endtask

	initial begin
		alu_chain();
		load_use();
		branch_paths();
		random_delay();
		halt_quiet();
		reset_restart();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- tb.f
hdl/cpu_pkg.sv
hdl/cpu_fetch.sv
hdl/cpu_decode.sv
hdl/cpu_exec.sv
hdl/cpu_memory.sv
hdl/cpu_regfile.sv
hdl/cpu_pipeline.sv
tb/tb_clock.sv
tb/tb_mem_model.sv
tb/pipeline_props.sv
tb/tb_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_top
FILELIST = tb.f
LOG = sim.log

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "STATUS: FAIL" $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
